//--- dv/weight_stim.txt
// Axxxxxxx expected burst address in the low 28 bits, in request order, cyclic
// 1Mxxcccc pop phase: M 0 steady, 1 random gaps, 2 stall cycles, 3 drain; 2xxxxxxx flush; F end
// matrix Q
A0000100 A0000104 A0000108 A000010C A0000110 A0000114 A0000118 A000011C
A0000120 A0000124 A0000128 A000012C A0000130 A0000134 A0000138 A000013C
A0000140 A0000144 A0000148 A000014C A0000150 A0000154 A0000158 A000015C
A0000160 A0000164 A0000168 A000016C A0000170 A0000174 A0000178 A000017C
A0000102 A0000106 A000010A A000010E A0000112 A0000116 A000011A A000011E
A0000122 A0000126 A000012A A000012E A0000132 A0000136 A000013A A000013E
A0000142 A0000146 A000014A A000014E A0000152 A0000156 A000015A A000015E
A0000162 A0000166 A000016A A000016E A0000172 A0000176 A000017A A000017E
// matrix K
A0000180 A0000184 A0000188 A000018C A0000190 A0000194 A0000198 A000019C
A00001A0 A00001A4 A00001A8 A00001AC A00001B0 A00001B4 A00001B8 A00001BC
A00001C0 A00001C4 A00001C8 A00001CC A00001D0 A00001D4 A00001D8 A00001DC
A00001E0 A00001E4 A00001E8 A00001EC A00001F0 A00001F4 A00001F8 A00001FC
A0000182 A0000186 A000018A A000018E A0000192 A0000196 A000019A A000019E
A00001A2 A00001A6 A00001AA A00001AE A00001B2 A00001B6 A00001BA A00001BE
A00001C2 A00001C6 A00001CA A00001CE A00001D2 A00001D6 A00001DA A00001DE
A00001E2 A00001E6 A00001EA A00001EE A00001F2 A00001F6 A00001FA A00001FE
// matrix V
A0000200 A0000204 A0000208 A000020C A0000210 A0000214 A0000218 A000021C
A0000220 A0000224 A0000228 A000022C A0000230 A0000234 A0000238 A000023C
A0000240 A0000244 A0000248 A000024C A0000250 A0000254 A0000258 A000025C
A0000260 A0000264 A0000268 A000026C A0000270 A0000274 A0000278 A000027C
A0000202 A0000206 A000020A A000020E A0000212 A0000216 A000021A A000021E
A0000222 A0000226 A000022A A000022E A0000232 A0000236 A000023A A000023E
A0000242 A0000246 A000024A A000024E A0000252 A0000256 A000025A A000025E
A0000262 A0000266 A000026A A000026E A0000272 A0000276 A000027A A000027E
// matrix MLP
A0000280 A0000284 A0000288 A000028C A0000290 A0000294 A0000298 A000029C
A00002A0 A00002A4 A00002A8 A00002AC A00002B0 A00002B4 A00002B8 A00002BC
A00002C0 A00002C4 A00002C8 A00002CC A00002D0 A00002D4 A00002D8 A00002DC
A00002E0 A00002E4 A00002E8 A00002EC A00002F0 A00002F4 A00002F8 A00002FC
A0000282 A0000286 A000028A A000028E A0000292 A0000296 A000029A A000029E
A00002A2 A00002A6 A00002AA A00002AE A00002B2 A00002B6 A00002BA A00002BE
A00002C2 A00002C6 A00002CA A00002CE A00002D2 A00002D6 A00002DA A00002DE
A00002E2 A00002E6 A00002EA A00002EE A00002F2 A00002F6 A00002FA A00002FE
// command sequence
100000C8
110000C8
120000C8
10000100
20000000
10000020
13000000
F0000000

//--- weight_fifo.f
src/weight_pkg.sv
src/weight_addr_gen.sv
src/weight_sync_fifo.sv
src/weight_fifo.sv
dv/weight_fifo_asserts.sv
dv/weight_fifo_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the weight prefetch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module weight_fifo_tb \
    -f weight_fifo.f

# the log decides the result, so a failing run must not stop the script here
./obj_dir/Vweight_fifo_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

//--- dv/weight_fifo_tb.sv
/*
 * testbench for the weight prefetch top
 * DDR and systolic array models, driven from the stim file
 */
`timescale 1ns/1ps

module weight_fifo_tb;

    localparam weight_pkg::ddr_addr_t  WEIGHT_BASE  = 28'h0100;
    localparam weight_pkg::burst_len_t BURST_LEN    = 8'd2;  // 16 weights of 8 bits per burst
    localparam int                     ALMOST_FULL  = 24;
    localparam int                     ALMOST_EMPTY = 4;

    logic                    s_clk;
    logic                    s_rst;
    weight_pkg::ddr_rd_rsp_t ddr_rsp;
    weight_pkg::ddr_addr_t   rd_burst_addr;
    weight_pkg::burst_len_t  rd_burst_len;
    logic                    rd_burst_req;
    weight_pkg::ddr_data_t   weight_data;
    logic                    weight_pop;
    logic                    weight_ready;
    logic                    load_finish;

    logic [31:0]           stim_mem [512];
    weight_pkg::ddr_addr_t exp_addr [$];
    logic [31:0]           cmds [$];
    weight_pkg::ddr_data_t exp_q [$];   // words sent by DDR, not yet popped
    int                    addr_idx;
    int                    watch_cycles = 0;
    logic [31:0]           lfsr_state = 32'h6dcf;
    logic                  ddr_hold;    // DDR model holds back its data
    logic                  ddr_busy;    // burst data on the bus
    logic                  flush_wait;  // next request must restart at the base

    weight_fifo weight_fifo_i (.*);

    always #20 s_clk = ~s_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input weight_pkg::ddr_addr_t got,
                              input weight_pkg::ddr_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_len(input string name, input weight_pkg::burst_len_t got,
                             input weight_pkg::burst_len_t exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_data(input string name, input weight_pkg::ddr_data_t got,
                              input weight_pkg::ddr_data_t exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // galois form, taps 32 22 2 1
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // upper half address plus index, lower half its inverse
    function automatic weight_pkg::ddr_data_t make_word(input weight_pkg::ddr_addr_t addr,
                                                       input int idx);
        logic [31:0] v;
        v = 32'(addr) + 32'(idx);
        return {v, ~v};
    endfunction

    // pops one word per cycle at most; mode 1 adds random gaps
    task automatic pop_words(input int mode, input int count);
        int   popped;
        logic pend;
        logic d;
        popped = 0;
        pend   = 1'b0;
        while (popped < count || pend) begin
            @(negedge s_clk);
            if (pend) begin
                check_data("weight_data", weight_data, exp_q.pop_front());
                popped++;
            end
            d = (popped < count) && weight_ready && (mode == 0 || take_bits(1) == 1);
            @(posedge s_clk);
            weight_pop <= d;
            pend = d;
        end
    endtask

    task automatic hold_pops(input int cycles);
        repeat (cycles) @(negedge s_clk);
        check_flag("rd_burst_req", rd_burst_req, 1'b0);
        if (exp_q.size() < ALMOST_FULL || exp_q.size() > ALMOST_FULL + int'(BURST_LEN) - 1)
            report_failure($sformatf("Error buffer holds %0d words after the stall", exp_q.size()));
    endtask

    task automatic flush_mid_burst();
        logic pend;
        logic fired;
        logic d;
        pend  = 1'b0;
        fired = 1'b0;
        while (!fired || pend) begin
            @(negedge s_clk);
            if (pend) begin
                check_data("weight_data", weight_data, exp_q.pop_front());
                pend = 1'b0;
            end
            if (!fired && ddr_busy) begin
                @(posedge s_clk);
                load_finish <= 1'b1;
                weight_pop  <= 1'b0;
                flush_wait = 1'b1;
                fired      = 1'b1;
                @(posedge s_clk);
                load_finish <= 1'b0;
            end else if (!fired) begin
                d = weight_ready;
                @(posedge s_clk);
                weight_pop <= d;
                pend = d;
            end
        end
        while (flush_wait) @(negedge s_clk);
    endtask

    // DDR held back, array empties the buffer
    task automatic drain_buffer();
        logic pend;
        logic d;
        logic done;
        @(negedge s_clk);
        ddr_hold = 1'b1;
        while (ddr_busy) @(negedge s_clk);
        repeat (2) @(negedge s_clk);
        pend = 1'b0;
        done = 1'b0;
        while (!done) begin
            check_flag("weight_ready", weight_ready, exp_q.size() >= ALMOST_EMPTY);
            if (pend)
                check_data("weight_data", weight_data, exp_q.pop_front());
            d = (exp_q.size() > 0);
            done = !d && !pend;
            @(posedge s_clk);
            weight_pop <= d;
            pend = d;
            @(negedge s_clk);
        end
    endtask

    initial begin : ddr_model
        weight_pkg::ddr_addr_t  addr;
        weight_pkg::burst_len_t len;
        weight_pkg::ddr_data_t  w;
        int                     gap;
        wait (watch_cycles > 0 && !s_rst);
        forever begin
            @(negedge s_clk);
            if (rd_burst_req) begin
                addr = rd_burst_addr;
                len  = rd_burst_len;
                check_len("rd_burst_len", len, BURST_LEN);
                if (flush_wait) begin
                    check_addr("rd_burst_addr", addr, WEIGHT_BASE);
                    exp_q.delete();
                    addr_idx   = 0;
                    flush_wait = 1'b0;
                end
                check_addr("rd_burst_addr", addr, exp_addr[addr_idx]);
                addr_idx = (addr_idx + 1) % exp_addr.size();
                gap = 1 + take_bits(2);
                repeat (gap) @(posedge s_clk);
                while (ddr_hold) @(posedge s_clk);
                for (int i = 0; i < int'(len); i++) begin
                    if (i > 0)
                        @(posedge s_clk);
                    w = make_word(addr, i);
                    ddr_rsp <= {w, 1'b1, i == int'(len) - 1};
                    exp_q.push_back(w);
                    ddr_busy = (i != int'(len) - 1);
                end
                @(posedge s_clk);
                ddr_rsp <= '0;
            end
        end
    end

    initial begin : watchdog
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge s_clk);
        report_failure("Error watchdog expired, the run hung");
    end

    initial begin : assert_watch
        wait (weight_fifo_i.asserts_i.fail_count != 0);
        report_failure("a protocol assertion on the DUT failed");
    end

    initial begin : main
        int total_pops;
        int i;
        s_clk = 1'b0;
        s_rst = 1'b1;
        ddr_rsp = '0;
        weight_pop = 1'b0;
        load_finish = 1'b0;
        ddr_hold = 1'b0;
        ddr_busy = 1'b0;
        flush_wait = 1'b0;
        addr_idx = 0;
        total_pops = 0;
        foreach (stim_mem[k])
            stim_mem[k] = {4'hF, 28'(k)};
        $readmemh("dv/weight_stim.txt", stim_mem);
        i = 0;
        while (stim_mem[i][31:28] != 4'hF) begin
            if (stim_mem[i][31:28] == 4'hA)
                exp_addr.push_back(stim_mem[i][27:0]);
            else
                cmds.push_back(stim_mem[i]);
            if (stim_mem[i][31:28] == 4'h1 && stim_mem[i][27:24] <= 4'h1)
                total_pops += int'(stim_mem[i][15:0]);
            i++;
        end
        if (exp_addr.size() == 0)
            report_failure("Error stim file holds no burst addresses");
        watch_cycles = total_pops * 20 + 2000;

        repeat (2) @(posedge s_clk);
        @(negedge s_clk);
        check_flag("rd_burst_req", rd_burst_req, 1'b0);
        check_flag("weight_ready", weight_ready, 1'b0);
        check_addr("rd_burst_addr", rd_burst_addr, WEIGHT_BASE);
        repeat (2) @(posedge s_clk);
        s_rst <= 1'b0;
        @(negedge s_clk);
        check_flag("rd_burst_req", rd_burst_req, 1'b0);
        check_flag("weight_ready", weight_ready, 1'b0);
        check_addr("rd_burst_addr", rd_burst_addr, WEIGHT_BASE);

        foreach (cmds[k]) begin
            if (cmds[k][31:28] == 4'h2)
                flush_mid_burst();
            else if (cmds[k][27:24] == 4'h2)
                hold_pops(int'(cmds[k][15:0]));
            else if (cmds[k][27:24] == 4'h3)
                drain_buffer();
            else
                pop_words(int'(cmds[k][27:24]), int'(cmds[k][15:0]));
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- dv/weight_fifo_asserts.sv
/*
 * protocol checks on the weight prefetch top
 * request drop after finish, buffer overflow and underflow, reset
 */
`timescale 1ns/1ps

module weight_fifo_asserts #(
    parameter int FIFO_DEPTH = 32
) (
    input logic                    s_clk,
    input logic                    s_rst,
    input logic                    rd_burst_req,
    input weight_pkg::ddr_rd_rsp_t ddr_rsp,
    input weight_pkg::fifo_level_t buf_level,
    input logic                    weight_pop
);

    int unsigned fail_count = 0;  // watched by the testbench

    // finish only closes an open request, which then drops
    req_drops_after_finish: assert property (@(posedge s_clk) disable iff (s_rst)
        ddr_rsp.finish |-> rd_burst_req ##1 !rd_burst_req)
        else begin
            fail_count++;
            $error("finish outside a request or request still high after it");
        end

    no_write_when_full: assert property (@(posedge s_clk) disable iff (s_rst)
        ddr_rsp.valid |-> buf_level != weight_pkg::fifo_level_t'(FIFO_DEPTH))
        else begin
            fail_count++;
            $error("write into a full buffer");
        end

    no_pop_when_empty: assert property (@(posedge s_clk) disable iff (s_rst)
        weight_pop |-> buf_level != '0)
        else begin
            fail_count++;
            $error("pop from an empty buffer");
        end

    // low in reset and in the first cycle out of it
    req_low_in_reset: assert property (@(posedge s_clk)
        s_rst |-> !rd_burst_req ##1 !rd_burst_req)
        else begin
            fail_count++;
            $error("burst request high during reset");
        end

endmodule

bind weight_fifo weight_fifo_asserts #(.FIFO_DEPTH(FIFO_DEPTH)) asserts_i (
    .s_clk        (s_clk),
    .s_rst        (s_rst),
    .rd_burst_req (rd_burst_req),
    .ddr_rsp      (ddr_rsp),
    .buf_level    (buf_level),
    .weight_pop   (weight_pop)
);

//--- src/weight_fifo.sv
/*
 * weight prefetch top: DDR burst requests, flush on load finish,
 * tiled address walker and the on-chip weight buffer
 */
`timescale 1ns/1ps

module weight_fifo #(
    parameter int                    FMAP_CHANNELS = 32,
    parameter int                    UNIT_NUM      = 16,
    parameter int                    QUANT_BITS    = 8,
    parameter int                    NUM_MATRICES  = 4,
    parameter weight_pkg::ddr_addr_t WEIGHT_BASE   = 28'h0100,
    parameter int                    FIFO_DEPTH    = 32,
    parameter int                    ALMOST_FULL   = 24,
    parameter int                    ALMOST_EMPTY  = 4
) (
    input  logic                    s_clk,
    input  logic                    s_rst,
    // DDR side
    input  weight_pkg::ddr_rd_rsp_t ddr_rsp,
    output weight_pkg::ddr_addr_t   rd_burst_addr,
    output weight_pkg::burst_len_t  rd_burst_len,
    output logic                    rd_burst_req,
    // systolic array side
    output weight_pkg::ddr_data_t   weight_data,
    input  logic                    weight_pop,
    output logic                    weight_ready,
    input  logic                    load_finish
);

    logic                    flush_pend;   // load finish seen, waiting for idle bus
    logic                    flush_now;
    logic                    buf_afull;
    logic                    buf_aempty;
    weight_pkg::fifo_level_t buf_level;

    // one tile row per burst
    assign rd_burst_len = weight_pkg::burst_len_t'(UNIT_NUM * QUANT_BITS
                                                   / weight_pkg::WORD_BITS);
    assign weight_ready = ~buf_aempty;
    assign flush_now    = flush_pend && !rd_burst_req;  // only between bursts

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            rd_burst_req <= 1'b0;
        end else if (ddr_rsp.finish) begin
            rd_burst_req <= 1'b0;  // at least one idle cycle between bursts
        end else if (!rd_burst_req && !buf_afull && !flush_pend) begin
            rd_burst_req <= 1'b1;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            flush_pend <= 1'b0;
        end else if (load_finish) begin
            flush_pend <= 1'b1;
        end else if (!rd_burst_req) begin
            flush_pend <= 1'b0;
        end
    end

    weight_addr_gen #(
        .FMAP_CHANNELS (FMAP_CHANNELS),
        .UNIT_NUM      (UNIT_NUM),
        .QUANT_BITS    (QUANT_BITS),
        .NUM_MATRICES  (NUM_MATRICES),
        .WEIGHT_BASE   (WEIGHT_BASE)
    ) addr_gen_i (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .burst_done (ddr_rsp.finish),
        .restart    (flush_now),
        .burst_addr (rd_burst_addr)
    );

    weight_sync_fifo #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .ALMOST_FULL  (ALMOST_FULL),
        .ALMOST_EMPTY (ALMOST_EMPTY)
    ) buf_i (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .clear        (flush_now),
        .wr_en        (ddr_rsp.valid),
        .wr_data      (ddr_rsp.data),
        .rd_en        (weight_pop),
        .rd_data      (weight_data),
        .level        (buf_level),   // watched by the bound checks
        .almost_full  (buf_afull),
        .almost_empty (buf_aempty)
    );

endmodule

//--- src/weight_sync_fifo.sv
/*
 * synchronous weight buffer, circular register store
 * fill level plus registered almost-full / almost-empty flags
 */
`timescale 1ns/1ps

module weight_sync_fifo #(
    parameter int FIFO_DEPTH   = 32,
    parameter int ALMOST_FULL  = 24,
    parameter int ALMOST_EMPTY = 4
) (
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    clear,
    input  logic                    wr_en,
    input  weight_pkg::ddr_data_t   wr_data,
    input  logic                    rd_en,
    output weight_pkg::ddr_data_t   rd_data,
    output weight_pkg::fifo_level_t level,
    output logic                    almost_full,
    output logic                    almost_empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    weight_pkg::ddr_data_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic                    do_wr;
    logic                    do_rd;
    weight_pkg::fifo_level_t level_next;

    // writes into a full buffer are dropped, empty pops ignored
    assign do_wr = wr_en && (level != weight_pkg::fifo_level_t'(FIFO_DEPTH));
    assign do_rd = rd_en && (level != '0);

    assign rd_data = mem[rd_ptr];  // head word, shown before the pop

    always_comb begin
        level_next = level;
        if (clear) begin
            level_next = '0;
        end else if (do_wr && !do_rd) begin
            level_next = level + 1'b1;
        end else if (do_rd && !do_wr) begin
            level_next = level - 1'b1;
        end
    end

    always_ff @(posedge s_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                // wrap by compare, depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // flags follow the next level so they line up with level itself
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            level        <= '0;
            almost_full  <= 1'b0;
            almost_empty <= 1'b1;
        end else begin
            level        <= level_next;
            almost_full  <= (level_next >= weight_pkg::fifo_level_t'(ALMOST_FULL));
            almost_empty <= (level_next < weight_pkg::fifo_level_t'(ALMOST_EMPTY));
        end
    end

endmodule

//--- src/weight_addr_gen.sv
/*
 * tiled burst address walker for the Q, K, V and MLP weight matrices
 * order: row, row group, column tile, matrix; wraps to the weight base
 */
`timescale 1ns/1ps

module weight_addr_gen #(
    parameter int                    FMAP_CHANNELS = 32,
    parameter int                    UNIT_NUM      = 16,
    parameter int                    QUANT_BITS    = 8,
    parameter int                    NUM_MATRICES  = 4,
    parameter weight_pkg::ddr_addr_t WEIGHT_BASE   = 28'h0100
) (
    input  logic                  s_clk,
    input  logic                  s_rst,
    input  logic                  burst_done,  // finish of the current burst
    input  logic                  restart,     // flush back to the base
    output weight_pkg::ddr_addr_t burst_addr
);

    localparam int GROUPS = FMAP_CHANNELS / UNIT_NUM;  // row groups, also column tiles
    localparam int ROW_W  = (UNIT_NUM > 1) ? $clog2(UNIT_NUM) : 1;
    localparam int GRP_W  = (GROUPS > 1) ? $clog2(GROUPS) : 1;
    localparam int MAT_W  = (NUM_MATRICES > 1) ? $clog2(NUM_MATRICES) : 1;

    localparam weight_pkg::ddr_addr_t ROW_STRIDE =
        weight_pkg::ddr_addr_t'(FMAP_CHANNELS * QUANT_BITS / weight_pkg::WORD_BITS);
    localparam weight_pkg::ddr_addr_t TILE_STRIDE =
        weight_pkg::ddr_addr_t'(UNIT_NUM * QUANT_BITS / weight_pkg::WORD_BITS);
    localparam weight_pkg::ddr_addr_t GROUP_STRIDE =
        weight_pkg::ddr_addr_t'(UNIT_NUM * FMAP_CHANNELS * QUANT_BITS / weight_pkg::WORD_BITS);
    localparam weight_pkg::ddr_addr_t MAT_STRIDE =
        weight_pkg::ddr_addr_t'(FMAP_CHANNELS * FMAP_CHANNELS * QUANT_BITS
                                / weight_pkg::WORD_BITS);
    // from the last tile of one matrix to the first tile of the next
    localparam weight_pkg::ddr_addr_t MAT_JUMP =
        MAT_STRIDE - weight_pkg::ddr_addr_t'(GROUPS - 1) * TILE_STRIDE;

    logic [ROW_W-1:0] row_cnt;
    logic [GRP_W-1:0] grp_cnt;
    logic [GRP_W-1:0] tile_cnt;
    logic [MAT_W-1:0] mat_cnt;

    weight_pkg::ddr_addr_t tile_base;   // row 0 of group 0 in the current tile
    weight_pkg::ddr_addr_t group_base;  // row 0 of the current row group

    logic last_row;
    logic last_grp;
    logic last_tile;
    logic last_mat;

    assign last_row  = (row_cnt == ROW_W'(UNIT_NUM - 1));
    assign last_grp  = (grp_cnt == GRP_W'(GROUPS - 1));
    assign last_tile = (tile_cnt == GRP_W'(GROUPS - 1));
    assign last_mat  = (mat_cnt == MAT_W'(NUM_MATRICES - 1));

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            row_cnt    <= '0;
            grp_cnt    <= '0;
            tile_cnt   <= '0;
            mat_cnt    <= '0;
            tile_base  <= WEIGHT_BASE;
            group_base <= WEIGHT_BASE;
            burst_addr <= WEIGHT_BASE;
        end else if (restart) begin
            row_cnt    <= '0;
            grp_cnt    <= '0;
            tile_cnt   <= '0;
            mat_cnt    <= '0;
            tile_base  <= WEIGHT_BASE;
            group_base <= WEIGHT_BASE;
            burst_addr <= WEIGHT_BASE;
        end else if (burst_done) begin
            if (!last_row) begin
                row_cnt    <= row_cnt + 1'b1;
                burst_addr <= burst_addr + ROW_STRIDE;  // next row in the group
            end else if (!last_grp) begin
                row_cnt    <= '0;
                grp_cnt    <= grp_cnt + 1'b1;
                group_base <= group_base + GROUP_STRIDE;
                burst_addr <= group_base + GROUP_STRIDE;
            end else if (!last_tile) begin
                // next column tile, back to the top row group
                row_cnt    <= '0;
                grp_cnt    <= '0;
                tile_cnt   <= tile_cnt + 1'b1;
                tile_base  <= tile_base + TILE_STRIDE;
                group_base <= tile_base + TILE_STRIDE;
                burst_addr <= tile_base + TILE_STRIDE;
            end else if (!last_mat) begin
                row_cnt    <= '0;
                grp_cnt    <= '0;
                tile_cnt   <= '0;
                mat_cnt    <= mat_cnt + 1'b1;
                tile_base  <= tile_base + MAT_JUMP;
                group_base <= tile_base + MAT_JUMP;
                burst_addr <= tile_base + MAT_JUMP;
            end else begin
                // whole weight set read, start over
                row_cnt    <= '0;
                grp_cnt    <= '0;
                tile_cnt   <= '0;
                mat_cnt    <= '0;
                tile_base  <= WEIGHT_BASE;
                group_base <= WEIGHT_BASE;
                burst_addr <= WEIGHT_BASE;
            end
        end
    end

endmodule

//--- src/weight_pkg.sv
/*
 * weight prefetch shared types
 * DDR word, address, burst length, fill level and read response
 */
package weight_pkg;

    // DDR bus word width, used for stride arithmetic
    localparam int WORD_BITS = 64;

    // one DDR data word
    typedef logic [WORD_BITS-1:0] ddr_data_t;

    // DDR word address
    typedef logic [27:0] ddr_addr_t;

    // burst length in words
    typedef logic [7:0] burst_len_t;

    // buffer fill count, depth up to 128
    typedef logic [7:0] fifo_level_t;

    // read response from the DDR controller
    typedef struct packed {
        ddr_data_t data;    // returned word
        logic      valid;   // word strobe
        logic      finish;  // last word of the burst
    } ddr_rd_rsp_t;

endpackage
